//--- hw/mem_reset_sync_scan.sv
`timescale 1ns/100ps
`default_nettype none

// Read clock reset synchronizer
// Assertion is asynchronous, release takes two rclk edges
module mem_reset_sync_scan (
     input  logic rclk
    ,input  logic arst_n
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_n_sync
);

    // Two flop stages, a one is shifted in once arst_n is released
    logic [1:0] sync_q;

    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // In scan mode the tester drives the reset directly and the flops are bypassed
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[1];

endmodule

`default_nettype wire

//--- hw/rf_array_pg.sv
`timescale 1ns/100ps
`default_nettype none

// Behavioral two-port storage array with power gating
// Storage, valid bits and the power-enable chain live on wclk, the read register on rclk
module rf_array_pg import rf_pkg::*; #(
     parameter int DEPTH         = RF_DEPTH_DEF
    ,parameter int WIDTH         = RF_WIDTH_DEF
    ,parameter int PWR_CHAIN_DLY = PWR_CHAIN_DLY_DEF
) (
     input  logic                     wclk
    ,input  logic                     arst_n
    ,input  logic                     we
    ,input  logic [$clog2(DEPTH)-1:0] waddr
    ,input  logic [WIDTH-1:0]         wdata

    ,input  logic                     rclk
    ,input  logic                     rrst_n
    ,input  logic                     re
    ,input  logic [$clog2(DEPTH)-1:0] raddr
    ,output logic [WIDTH-1:0]         rdata

    ,rf_pwr_if.mem                    pwr
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0]         mem_q [DEPTH];
    logic [DEPTH-1:0]         valid_q;
    logic [PWR_CHAIN_DLY-1:0] chain_q;
    logic                     gated;
    logic [WIDTH-1:0]         rd_q;
    logic [AW-1:0]            rd_idx;

    // --------------------
    // Power-enable chain
    // --------------------

    // The enable ripples through the array segments one wclk at a time
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            chain_q <= '0;
        end else begin
            chain_q[0] <= pwr.pwr_enable_b;
            for (int i = 1; i < PWR_CHAIN_DLY; i++) begin
                chain_q[i] <= chain_q[i-1];
            end
        end
    end

    // Once the last segment sees the enable, the whole array is unpowered
    assign gated                = chain_q[PWR_CHAIN_DLY-1];
    assign pwr.pwr_enable_b_out = gated;

    // --------------------
    // Write side
    // --------------------

    // Valid bits model retention, losing power drops every entry
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (gated) begin
            valid_q <= '0;
        end else if (we) begin
            valid_q[waddr] <= 1'b1;
        end
    end

    // Data cells, writes into an unpowered array are lost
    always_ff @(posedge wclk) begin
        if (we && !gated) begin
            mem_q[waddr] <= wdata;
        end
    end

    // --------------------
    // Read side
    // --------------------

    assign rd_idx = raddr;

    // Entries that were never rewritten after power-up read back as zero
    // The output register also drops its content while isolated
    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            rd_q <= '0;
        end else if (pwr.isol_en) begin
            rd_q <= '0;
        end else if (re) begin
            rd_q <= valid_q[rd_idx] ? mem_q[rd_idx] : '0;
        end
    end

    // Isolation clamp, covers the first cycle before rd_q clears
    assign rdata = pwr.isol_en ? '0 : rd_q;

endmodule

`default_nettype wire

//--- hw/rf_pg_top.sv
`timescale 1ns/100ps
`default_nettype none

// Top level of the power-gated register file subsystem
// Joins the power sequencer and the wrapper through the power interface
module rf_pg_top import rf_pkg::*; #(
     parameter int DEPTH         = RF_DEPTH_DEF
    ,parameter int WIDTH         = RF_WIDTH_DEF
    ,parameter int PWR_CHAIN_DLY = PWR_CHAIN_DLY_DEF
) (
     input  logic                     wclk
    ,input  logic                     rclk
    ,input  logic                     arst_n

    ,input  logic                     we
    ,input  logic [$clog2(DEPTH)-1:0] waddr
    ,input  logic [WIDTH-1:0]         wdata

    ,input  logic                     re
    ,input  logic [$clog2(DEPTH)-1:0] raddr
    ,output logic [WIDTH-1:0]         rdata

    ,input  pwr_cmd_e                 pwr_cmd
    ,output pwr_state_e               pwr_state

    ,input  logic                     fscan_rstbypen
    ,input  logic                     fscan_byprst_b
);

    rf_pwr_if pwr_if ();

    // Sequencer runs on the read clock
    rf_pwr_seq u_seq (
         .rclk      (rclk)
        ,.arst_n    (arst_n)
        ,.pwr_cmd   (pwr_cmd)
        ,.pwr       (pwr_if.seq)
        ,.pwr_state (pwr_state)
    );

    rf_pg_wrap #(
         .DEPTH         (DEPTH)
        ,.WIDTH         (WIDTH)
        ,.PWR_CHAIN_DLY (PWR_CHAIN_DLY)
    ) u_wrap (
         .wclk           (wclk)
        ,.arst_n         (arst_n)
        ,.we             (we)
        ,.waddr          (waddr)
        ,.wdata          (wdata)
        ,.rclk           (rclk)
        ,.re             (re)
        ,.raddr          (raddr)
        ,.rdata          (rdata)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.pwr            (pwr_if.mem)
    );

endmodule

`default_nettype wire

//--- hw/rf_pg_wrap.sv
`timescale 1ns/100ps
`default_nettype none

// Power-gated register file wrapper
// Synchronizes the read-side reset and hands the ports to the storage array
module rf_pg_wrap import rf_pkg::*; #(
     parameter int DEPTH         = RF_DEPTH_DEF
    ,parameter int WIDTH         = RF_WIDTH_DEF
    ,parameter int PWR_CHAIN_DLY = PWR_CHAIN_DLY_DEF
) (
     input  logic                     wclk
    ,input  logic                     arst_n
    ,input  logic                     we
    ,input  logic [$clog2(DEPTH)-1:0] waddr
    ,input  logic [WIDTH-1:0]         wdata

    ,input  logic                     rclk
    ,input  logic                     re
    ,input  logic [$clog2(DEPTH)-1:0] raddr
    ,output logic [WIDTH-1:0]         rdata

    ,input  logic                     fscan_rstbypen
    ,input  logic                     fscan_byprst_b

    ,rf_pwr_if.mem                    pwr
);

    // Read domain reset after synchronization or scan bypass
    logic rrst_n;

    mem_reset_sync_scan u_rst_sync (
         .rclk           (rclk)
        ,.arst_n         (arst_n)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
        ,.rst_n_sync     (rrst_n)
    );

    // The sequencer may only start a power command once the read side is out of reset
    assign pwr.mem_ready = rrst_n;

    rf_array_pg #(
         .DEPTH         (DEPTH)
        ,.WIDTH         (WIDTH)
        ,.PWR_CHAIN_DLY (PWR_CHAIN_DLY)
    ) u_array (
         .wclk   (wclk)
        ,.arst_n (arst_n)
        ,.we     (we)
        ,.waddr  (waddr)
        ,.wdata  (wdata)
        ,.rclk   (rclk)
        ,.rrst_n (rrst_n)
        ,.re     (re)
        ,.raddr  (raddr)
        ,.rdata  (rdata)
        ,.pwr    (pwr)
    );

endmodule

`default_nettype wire

//--- hw/rf_pkg.sv
`default_nettype none

// Shared sizes and encodings for the power-gated register file
package rf_pkg;

    // --------------------
    // Default sizes
    // --------------------

    // Number of entries in the storage array
    localparam int RF_DEPTH_DEF = 16;

    // Width of one entry in bits
    localparam int RF_WIDTH_DEF = 160;

    // Length of the power-enable chain through the array, counted in wclk cycles
    localparam int PWR_CHAIN_DLY_DEF = 4;

    // --------------------
    // Power control encodings
    // --------------------

    // Single-cycle power command strobe, NONE means no request this cycle
    typedef enum logic [1:0] {
        PWR_CMD_NONE = 2'd0,
        PWR_CMD_DOWN = 2'd1,
        PWR_CMD_UP   = 2'd2
    } pwr_cmd_e;

    // Sequencer states
    // Power-down walks ON, ISOLATE, GATING, GATED
    // Power-up walks GATED, WAKING, DEISOLATE, ON
    typedef enum logic [2:0] {
        PWR_ON        = 3'd0,
        PWR_ISOLATE   = 3'd1,
        PWR_GATING    = 3'd2,
        PWR_GATED     = 3'd3,
        PWR_WAKING    = 3'd4,
        PWR_DEISOLATE = 3'd5
    } pwr_state_e;

endpackage

`default_nettype wire

//--- hw/rf_pwr_if.sv
`timescale 1ns/100ps
`default_nettype none

// Power control bundle between the sequencer and the register file wrapper
interface rf_pwr_if;

    // Read isolation, clamps read data to zero while high
    logic isol_en;
    // Power enable to the array, active low, so high means power removed
    logic pwr_enable_b;
    // Far end of the power-enable chain, serves as the acknowledge
    logic pwr_enable_b_out;
    // Read-side reset has been released
    logic mem_ready;

    // Sequencer side
    modport seq (
        output isol_en,
        output pwr_enable_b,
        input  pwr_enable_b_out,
        input  mem_ready
    );

    // Memory side
    modport mem (
        input  isol_en,
        input  pwr_enable_b,
        output pwr_enable_b_out,
        output mem_ready
    );

endinterface

`default_nettype wire

//--- hw/rf_pwr_seq.sv
`timescale 1ns/100ps
`default_nettype none

// Power sequencer on rclk
// Down order is isolate then gate, up order is ungate then deisolate
module rf_pwr_seq import rf_pkg::*; (
     input  logic       rclk
    ,input  logic       arst_n
    ,input  pwr_cmd_e   pwr_cmd
    ,rf_pwr_if.seq      pwr
    ,output pwr_state_e pwr_state
);

    pwr_state_e state_q;
    pwr_state_e state_d;
    logic [1:0] ack_sync_q;
    logic       ack;

    // --------------------
    // Acknowledge synchronizer
    // --------------------

    // The chain end comes from the wclk domain
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            ack_sync_q <= 2'b00;
        end else begin
            ack_sync_q <= {ack_sync_q[0], pwr.pwr_enable_b_out};
        end
    end

    assign ack = ack_sync_q[1];

    // --------------------
    // State machine
    // --------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Down requests wait until the read side is out of reset
            PWR_ON: begin
                if (pwr.mem_ready && pwr_cmd == PWR_CMD_DOWN) begin
                    state_d = PWR_ISOLATE;
                end
            end
            // One cycle of isolation before the enable is dropped
            PWR_ISOLATE: state_d = PWR_GATING;
            // Wait for the whole chain to report power off
            PWR_GATING: begin
                if (ack) begin
                    state_d = PWR_GATED;
                end
            end
            PWR_GATED: begin
                if (pwr_cmd == PWR_CMD_UP) begin
                    state_d = PWR_WAKING;
                end
            end
            // Wait for the chain to report power back on
            PWR_WAKING: begin
                if (!ack) begin
                    state_d = PWR_DEISOLATE;
                end
            end
            PWR_DEISOLATE: state_d = PWR_ON;
            default: state_d = PWR_ON;
        endcase
    end

    // Controls are registered from the next state so they change with the state and never glitch
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q          <= PWR_ON;
            pwr.isol_en      <= 1'b0;
            pwr.pwr_enable_b <= 1'b0;
        end else begin
            state_q          <= state_d;
            pwr.isol_en      <= (state_d != PWR_ON);
            pwr.pwr_enable_b <= (state_d == PWR_GATING) || (state_d == PWR_GATED);
        end
    end

    assign pwr_state = state_q;

endmodule

`default_nettype wire

//--- list.f
hw/rf_pkg.sv
hw/rf_pwr_if.sv
hw/mem_reset_sync_scan.sv
hw/rf_array_pg.sv
hw/rf_pg_wrap.sv
hw/rf_pwr_seq.sv
hw/rf_pg_top.sv
sim/rf_pg_tb.sv

//--- sim/rf_pg_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rf_pg_tb import rf_pkg::*; ();

    localparam int DEPTH = RF_DEPTH_DEF;
    localparam int WIDTH = RF_WIDTH_DEF;
    localparam int AW    = $clog2(DEPTH);

    // Operations the stimulus table can request
    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_HOLD,
        OP_PWR_DOWN,
        OP_PWR_UP,
        OP_SCAN
    } op_e;

    // One table row is an operation, its address and the stable state expected afterwards
    typedef struct packed {
        op_e           op;
        logic [AW-1:0] addr;
        pwr_state_e    state;
    } row_t;

    logic             clk;
    logic             arst_n;
    logic             we;
    logic [AW-1:0]    waddr;
    logic [WIDTH-1:0] wdata;
    logic             re;
    logic [AW-1:0]    raddr;
    logic [WIDTH-1:0] rdata;
    pwr_cmd_e         pwr_cmd;
    pwr_state_e       pwr_state;
    logic             fscan_rstbypen;
    logic             fscan_byprst_b;

    row_t             table_q [$];
    int               row_count = 0;
    logic [15:0]      lfsr_q;

    // Reference model of the storage, its retention and the read register
    logic [WIDTH-1:0] model_mem [DEPTH];
    logic [DEPTH-1:0] model_valid;
    logic             model_gated;
    logic [WIDTH-1:0] model_rdata;

    // Both clock domains share one generator
    always #4 clk = ~clk;

    rf_pg_top #(
         .DEPTH         (DEPTH)
        ,.WIDTH         (WIDTH)
        ,.PWR_CHAIN_DLY (PWR_CHAIN_DLY_DEF)
    ) DUT (
         .wclk           (clk)
        ,.rclk           (clk)
        ,.arst_n         (arst_n)
        ,.we             (we)
        ,.waddr          (waddr)
        ,.wdata          (wdata)
        ,.re             (re)
        ,.raddr          (raddr)
        ,.rdata          (rdata)
        ,.pwr_cmd        (pwr_cmd)
        ,.pwr_state      (pwr_state)
        ,.fscan_rstbypen (fscan_rstbypen)
        ,.fscan_byprst_b (fscan_byprst_b)
    );

    // --------------------
    // Checks
    // --------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_rdata(input logic [WIDTH-1:0] exp);
        if (rdata !== exp) begin
            $display("FAILED rdata: expected 0x%h, actual 0x%h", exp, rdata);
            fail_run("Read data mismatch");
        end
    endtask

    task automatic check_state(input pwr_state_e exp);
        if (pwr_state !== exp) begin
            $display("FAILED pwr_state: expected 0x%h, actual 0x%h", exp, pwr_state);
            fail_run("Power state mismatch");
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1, the bit taken is the one shifted out
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic next_data(output logic [WIDTH-1:0] d);
        for (int i = 0; i < WIDTH; i++) begin
            d[i]   = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic do_write(input logic [AW-1:0] addr);
        logic [WIDTH-1:0] d;
        next_data(d);
        @(posedge clk);
        #1;
        we    = 1'b1;
        waddr = addr;
        wdata = d;
        @(posedge clk);
        #1;
        we = 1'b0;
        // An unpowered array drops the write
        if (!model_gated) begin
            model_mem[addr]   = d;
            model_valid[addr] = 1'b1;
        end
    endtask

    task automatic do_read(input logic [AW-1:0] addr);
        logic [WIDTH-1:0] exp;
        @(posedge clk);
        #1;
        re    = 1'b1;
        raddr = addr;
        @(posedge clk);
        #1;
        re = 1'b0;
        // Isolated reads and entries lost to power gating come back as zero
        if (model_gated || !model_valid[addr]) begin
            exp = '0;
        end else begin
            exp = model_mem[addr];
        end
        model_rdata = exp;
        check_rdata(exp);
    endtask

    // Address moves while re stays low, rdata must keep the last read
    task automatic do_hold(input logic [AW-1:0] addr);
        @(posedge clk);
        #1;
        raddr = addr;
        @(posedge clk);
        #1;
        @(posedge clk);
        #1;
        check_rdata(model_rdata);
    endtask

    task automatic do_power(input pwr_cmd_e cmd, input pwr_state_e target);
        logic ignored;
        // A down request only counts in PWR_ON and an up request only in PWR_GATED
        ignored = (cmd == PWR_CMD_DOWN) ? model_gated : !model_gated;
        @(posedge clk);
        #1;
        pwr_cmd = cmd;
        @(posedge clk);
        #1;
        pwr_cmd = PWR_CMD_NONE;
        if (ignored) begin
            // A dropped command must leave the state unchanged on every cycle
            for (int i = 0; i < 3; i++) begin
                check_state(target);
                @(posedge clk);
                #1;
            end
        end else begin
            while (pwr_state != target) begin
                @(posedge clk);
                #1;
            end
        end
        if (cmd == PWR_CMD_DOWN && !model_gated) begin
            model_gated = 1'b1;
            model_valid = '0;
            model_rdata = '0;
        end else if (cmd == PWR_CMD_UP && model_gated) begin
            model_gated = 1'b0;
            model_rdata = '0;
        end
    endtask

    // Scan bypass holds the read register in reset without touching the storage
    task automatic do_scan();
        @(posedge clk);
        #1;
        fscan_rstbypen = 1'b1;
        fscan_byprst_b = 1'b0;
        @(posedge clk);
        #1;
        model_rdata = '0;
        check_rdata('0);
        check_state(PWR_ON);
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        @(posedge clk);
        #1;
    endtask

    // --------------------
    // Stimulus table
    // --------------------

    task automatic add_row(input op_e op, input logic [AW-1:0] addr, input pwr_state_e st);
        row_t r;
        r.op    = op;
        r.addr  = addr;
        r.state = st;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        // Fresh array reads as zero
        for (int i = 0; i < DEPTH; i++) begin
            add_row(OP_READ, AW'(i), PWR_ON);
        end
        // Fill every entry, then read back in a scrambled order
        for (int i = 0; i < DEPTH; i++) begin
            add_row(OP_WRITE, AW'(i), PWR_ON);
        end
        for (int i = 0; i < DEPTH; i++) begin
            add_row(OP_READ, AW'(i * 5 + 3), PWR_ON);
        end
        add_row(OP_HOLD, AW'(7), PWR_ON);
        // Gate, repeat the down command, and try to write into the gated array
        add_row(OP_PWR_DOWN, AW'(0), PWR_GATED);
        add_row(OP_PWR_DOWN, AW'(0), PWR_GATED);
        add_row(OP_WRITE, AW'(3), PWR_GATED);
        add_row(OP_WRITE, AW'(5), PWR_GATED);
        add_row(OP_READ, AW'(3), PWR_GATED);
        // Wake up, nothing survived the gating
        add_row(OP_PWR_UP, AW'(0), PWR_ON);
        for (int i = 0; i < DEPTH; i++) begin
            add_row(OP_READ, AW'(i), PWR_ON);
        end
        add_row(OP_WRITE, AW'(2), PWR_ON);
        add_row(OP_WRITE, AW'(9), PWR_ON);
        add_row(OP_READ, AW'(2), PWR_ON);
        add_row(OP_READ, AW'(9), PWR_ON);
        add_row(OP_READ, AW'(4), PWR_ON);
        // An up command while already on is dropped
        add_row(OP_PWR_UP, AW'(0), PWR_ON);
        add_row(OP_READ, AW'(2), PWR_ON);
        // Scan reset bypass, then the contents must still be there
        add_row(OP_SCAN, AW'(0), PWR_ON);
        add_row(OP_READ, AW'(9), PWR_ON);
        add_row(OP_READ, AW'(2), PWR_ON);
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        row_t row;
        clk            = 1'b0;
        arst_n         = 1'b0;
        we             = 1'b0;
        waddr          = '0;
        wdata          = '0;
        re             = 1'b0;
        raddr          = '0;
        pwr_cmd        = PWR_CMD_NONE;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        lfsr_q         = 16'd39685;
        model_valid    = '0;
        model_gated    = 1'b0;
        model_rdata    = '0;
        build_table();
        row_count = table_q.size();

        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Read side reset needs two rclk edges to release
        repeat (3) @(posedge clk);
        #1;
        check_state(PWR_ON);
        check_rdata('0);

        foreach (table_q[i]) begin
            row = table_q[i];
            case (row.op)
                OP_WRITE:    do_write(row.addr);
                OP_READ:     do_read(row.addr);
                OP_HOLD:     do_hold(row.addr);
                OP_PWR_DOWN: do_power(PWR_CMD_DOWN, row.state);
                OP_PWR_UP:   do_power(PWR_CMD_UP, row.state);
                default:     do_scan();
            endcase
            check_state(row.state);
        end

        $display("TEST OK");
        $finish;
    end

    // Watchdog sized from the table, 40 cycles per row plus the reset time
    initial begin
        wait (row_count != 0);
        repeat (row_count * 40 + 16) @(posedge clk);
        fail_run("The run timed out before the stimulus table was finished");
    end

endmodule

`default_nettype wire
